/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_adder
FILELIST  := project.f
BUILD_DIR := obj_dir
PASS_MSG  := Simulation passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* project.f */
rtl/adder_pkg.sv
rtl/wb_pkg.sv
rtl/pg_group.sv
rtl/carry_tree.sv
rtl/sum_stage.sv
rtl/adder_wb_regs.sv
rtl/adder_wb_top.sv
test/tb_adder.sv

/* rtl/adder_pkg.sv */
package adder_pkg;

  // ------------------------------------------------------------------
  // Datapath geometry
  // ------------------------------------------------------------------

  localparam int DATA_WIDTH  = 64;  // Operand and sum width
  localparam int GROUP_WIDTH = 4;   // Bits per lookahead group

  // Number of lookahead groups across one operand
  localparam int NUM_GROUPS  = DATA_WIDTH / GROUP_WIDTH;

  // ------------------------------------------------------------------
  // Datapath types
  // ------------------------------------------------------------------

  // One full operand or sum word
  typedef logic [DATA_WIDTH-1:0] operand_t;

  // One bit per group, used for the group generate, propagate and
  // the carry into each group
  typedef logic [NUM_GROUPS-1:0] group_vec_t;

endpackage

/* rtl/adder_wb_regs.sv */
`timescale 1ns/1ps

module adder_wb_regs
  import adder_pkg::*;
  import wb_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [WB_ADDR_WIDTH-1:0] wb_adr,
  input  logic [WB_DATA_WIDTH-1:0] wb_wdata,
  input  logic [WB_SEL_WIDTH-1:0]  wb_sel,
  output logic [WB_DATA_WIDTH-1:0] wb_rdata,
  output logic                     wb_ack,
  input  operand_t                 sum,
  input  logic                     carry_out,
  output operand_t                 operand_a,
  output operand_t                 operand_b,
  output logic                     carry_in
);

  logic                     req;         // New transfer this cycle
  logic [WB_DATA_WIDTH-1:0] read_word;

  // Byte lane merge of a bus write into an existing word
  function automatic logic [WB_DATA_WIDTH-1:0] merge_lanes(
    input logic [WB_DATA_WIDTH-1:0] old_word,
    input logic [WB_DATA_WIDTH-1:0] new_word,
    input logic [WB_SEL_WIDTH-1:0]  sel
  );
    logic [WB_DATA_WIDTH-1:0] result;
    result = old_word;
    for (int i = 0; i < WB_SEL_WIDTH; i++)
      if (sel[i])
        result[i*8 +: 8] = new_word[i*8 +: 8];
    return result;
  endfunction

  // ------------------------------------------------------------------
  // Handshake
  // ------------------------------------------------------------------

  assign req = wb_cyc && wb_stb && !wb_ack;   // Ack blocks a second hit

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wb_ack <= 1'b0;
    else
      wb_ack <= req;   // Single cycle pulse
  end

  // ------------------------------------------------------------------
  // Operand and control registers
  // ------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      operand_a <= '0;
      operand_b <= '0;
      carry_in  <= 1'b0;
    end
    else if (req && wb_we)
    begin
      case (wb_adr)
        REG_A_LO: operand_a[WB_DATA_WIDTH-1:0] <=
                    merge_lanes(operand_a[WB_DATA_WIDTH-1:0], wb_wdata, wb_sel);
        REG_A_HI: operand_a[DATA_WIDTH-1:WB_DATA_WIDTH] <=
                    merge_lanes(operand_a[DATA_WIDTH-1:WB_DATA_WIDTH], wb_wdata, wb_sel);
        REG_B_LO: operand_b[WB_DATA_WIDTH-1:0] <=
                    merge_lanes(operand_b[WB_DATA_WIDTH-1:0], wb_wdata, wb_sel);
        REG_B_HI: operand_b[DATA_WIDTH-1:WB_DATA_WIDTH] <=
                    merge_lanes(operand_b[DATA_WIDTH-1:WB_DATA_WIDTH], wb_wdata, wb_sel);
        REG_CTRL:
          if (wb_sel[0])
            carry_in <= wb_wdata[CTRL_CIN_BIT];
        default: ;   // Result registers are read only
      endcase
    end
  end

  // ------------------------------------------------------------------
  // Read path
  // ------------------------------------------------------------------

  always_comb
  begin
    read_word = '0;
    case (wb_adr)
      REG_A_LO:   read_word = operand_a[WB_DATA_WIDTH-1:0];
      REG_A_HI:   read_word = operand_a[DATA_WIDTH-1:WB_DATA_WIDTH];
      REG_B_LO:   read_word = operand_b[WB_DATA_WIDTH-1:0];
      REG_B_HI:   read_word = operand_b[DATA_WIDTH-1:WB_DATA_WIDTH];
      REG_CTRL:   read_word[CTRL_CIN_BIT] = carry_in;
      REG_SUM_LO: read_word = sum[WB_DATA_WIDTH-1:0];               // Live sum
      REG_SUM_HI: read_word = sum[DATA_WIDTH-1:WB_DATA_WIDTH];
      REG_STATUS: read_word[STATUS_COUT_BIT] = carry_out;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (req && !wb_we)
      wb_rdata <= read_word;   // Valid with wb_ack
  end

endmodule

/* rtl/adder_wb_top.sv */
`timescale 1ns/1ps

module adder_wb_top
  import adder_pkg::*;
  import wb_pkg::*;
#(
  parameter int DATA_WIDTH  = adder_pkg::DATA_WIDTH,
  parameter int GROUP_WIDTH = adder_pkg::GROUP_WIDTH
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [WB_ADDR_WIDTH-1:0] wb_adr,
  input  logic [WB_DATA_WIDTH-1:0] wb_wdata,
  input  logic [WB_SEL_WIDTH-1:0]  wb_sel,
  output logic [WB_DATA_WIDTH-1:0] wb_rdata,
  output logic                     wb_ack
);

  localparam int NUM_GROUPS = DATA_WIDTH / GROUP_WIDTH;

  operand_t   operand_a;
  operand_t   operand_b;
  operand_t   sum;
  operand_t   bit_p;
  operand_t   prefix_g;
  operand_t   bit_prefix_p;
  group_vec_t group_g;
  group_vec_t group_p;
  group_vec_t group_carry;
  logic       carry_in;
  logic       carry_out;

  // ------------------------------------------------------------------
  // Bus slave
  // ------------------------------------------------------------------

  adder_wb_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_wdata  (wb_wdata),
    .wb_sel    (wb_sel),
    .wb_rdata  (wb_rdata),
    .wb_ack    (wb_ack),
    .sum       (sum),
    .carry_out (carry_out),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .carry_in  (carry_in)
  );

  // ------------------------------------------------------------------
  // Combinational adder
  // ------------------------------------------------------------------

  for (genvar gi = 0; gi < NUM_GROUPS; gi++)
  begin : g_group
    pg_group #(
      .GROUP_WIDTH (GROUP_WIDTH)
    ) u_pg (
      .a            (operand_a[gi*GROUP_WIDTH +: GROUP_WIDTH]),
      .b            (operand_b[gi*GROUP_WIDTH +: GROUP_WIDTH]),
      .bit_p        (bit_p[gi*GROUP_WIDTH +: GROUP_WIDTH]),
      .prefix_g     (prefix_g[gi*GROUP_WIDTH +: GROUP_WIDTH]),
      .bit_prefix_p (bit_prefix_p[gi*GROUP_WIDTH +: GROUP_WIDTH]),
      .group_g      (group_g[gi]),
      .group_p      (group_p[gi])
    );
  end

  carry_tree #(
    .NUM_GROUPS (NUM_GROUPS)
  ) u_tree (
    .group_g     (group_g),
    .group_p     (group_p),
    .carry_in    (carry_in),
    .group_carry (group_carry)
  );

  sum_stage #(
    .DATA_WIDTH  (DATA_WIDTH),
    .GROUP_WIDTH (GROUP_WIDTH)
  ) u_sum (
    .bit_p        (bit_p),
    .prefix_g     (prefix_g),
    .bit_prefix_p (bit_prefix_p),
    .group_carry  (group_carry),
    .carry_in     (carry_in),
    .sum          (sum),
    .carry_out    (carry_out)
  );

endmodule

/* rtl/carry_tree.sv */
`timescale 1ns/1ps

module carry_tree
  import adder_pkg::*;
#(
  parameter int NUM_GROUPS = adder_pkg::NUM_GROUPS
) (
  input  group_vec_t group_g,
  input  group_vec_t group_p,
  input  logic       carry_in,
  output group_vec_t group_carry   // Carry into each group
);

  localparam int LEVELS = $clog2(NUM_GROUPS);   // Prefix depth

  group_vec_t tree_g;   // Generate from group 0 up to group k
  group_vec_t tree_p;

  // ------------------------------------------------------------------
  // Parallel prefix across the groups
  // ------------------------------------------------------------------

  // The carry in is folded into group 0 first, so after the last level
  // tree_g[k] is the true carry out of group k.
  // Each level doubles the span; walking k downwards keeps the lower
  // entries at their previous level values while they are read.
  always_comb
  begin
    tree_g    = group_g;
    tree_p    = group_p;
    tree_g[0] = group_g[0] | (group_p[0] & carry_in);   // Seed with carry in
    for (int lvl = 0; lvl < LEVELS; lvl++)
    begin
      for (int k = NUM_GROUPS - 1; k >= (1 << lvl); k--)
      begin
        tree_g[k] = tree_g[k] | (tree_p[k] & tree_g[k - (1 << lvl)]);
        tree_p[k] = tree_p[k] & tree_p[k - (1 << lvl)];
      end
    end
  end

  // ------------------------------------------------------------------
  // Carry into each group
  // ------------------------------------------------------------------

  always_comb
  begin
    group_carry    = '0;         // Groups beyond NUM_GROUPS stay zero
    group_carry[0] = carry_in;   // Group 0 sees the carry in
    for (int k = 1; k < NUM_GROUPS; k++)
      group_carry[k] = tree_g[k-1];   // Carry out of the group below
  end

endmodule

/* rtl/pg_group.sv */
`timescale 1ns/1ps

module pg_group
  import adder_pkg::*;
#(
  parameter int GROUP_WIDTH = adder_pkg::GROUP_WIDTH
) (
  input  logic [GROUP_WIDTH-1:0] a,
  input  logic [GROUP_WIDTH-1:0] b,
  output logic [GROUP_WIDTH-1:0] bit_p,         // Bit propagate
  output logic [GROUP_WIDTH-1:0] prefix_g,      // Carry out of bit j, zero carry in
  output logic [GROUP_WIDTH-1:0] bit_prefix_p,  // Propagate from bit 0 up to bit j
  output logic                   group_g,
  output logic                   group_p
);

  logic [GROUP_WIDTH-1:0] bit_g;

  // ------------------------------------------------------------------
  // Bit level generate and propagate
  // ------------------------------------------------------------------

  assign bit_p = a ^ b;   // XOR form so the sum stage can reuse it
  assign bit_g = a & b;

  // ------------------------------------------------------------------
  // Running prefix inside the group
  // ------------------------------------------------------------------

  // Groups are narrow, so a short ripple of the prefix is enough here
  always_comb
  begin
    prefix_g[0]     = bit_g[0];
    bit_prefix_p[0] = bit_p[0];
    for (int j = 1; j < GROUP_WIDTH; j++)
    begin
      prefix_g[j]     = bit_g[j] | (bit_p[j] & prefix_g[j-1]);
      bit_prefix_p[j] = bit_p[j] & bit_prefix_p[j-1];
    end
  end

  // Whole group terms for the lookahead tree
  assign group_g = prefix_g[GROUP_WIDTH-1];
  assign group_p = bit_prefix_p[GROUP_WIDTH-1];

endmodule

/* rtl/sum_stage.sv */
`timescale 1ns/1ps

module sum_stage
  import adder_pkg::*;
#(
  parameter int DATA_WIDTH  = adder_pkg::DATA_WIDTH,
  parameter int GROUP_WIDTH = adder_pkg::GROUP_WIDTH
) (
  input  operand_t   bit_p,
  input  operand_t   prefix_g,
  input  operand_t   bit_prefix_p,
  input  group_vec_t group_carry,
  input  logic       carry_in,
  output operand_t   sum,
  output logic       carry_out
);

  localparam int LAST_GROUP = DATA_WIDTH / GROUP_WIDTH - 1;

  logic [DATA_WIDTH-1:0] bit_carry;   // Carry into each bit

  // ------------------------------------------------------------------
  // Bit carries from the group carries
  // ------------------------------------------------------------------

  for (genvar i = 0; i < DATA_WIDTH; i++)
  begin : g_bit
    localparam int GRP = i / GROUP_WIDTH;
    if (i == 0)
    begin : g_lsb
      assign bit_carry[i] = carry_in;   // Straight from the carry in
    end
    else if (i % GROUP_WIDTH == 0)
    begin : g_first
      assign bit_carry[i] = group_carry[GRP];
    end
    else
    begin : g_rest
      assign bit_carry[i] = prefix_g[i-1] | (bit_prefix_p[i-1] & group_carry[GRP]);
    end
  end

  assign sum = operand_t'(bit_p[DATA_WIDTH-1:0] ^ bit_carry);

  // True carry out of the top bit
  assign carry_out = prefix_g[DATA_WIDTH-1] |
                     (bit_prefix_p[DATA_WIDTH-1] & group_carry[LAST_GROUP]);

endmodule

/* rtl/wb_pkg.sv */
package wb_pkg;

  // ------------------------------------------------------------------
  // Bus geometry
  // ------------------------------------------------------------------

  localparam int WB_DATA_WIDTH = 32;                  // Bus data width
  localparam int WB_ADDR_WIDTH = 3;                   // Word address
  localparam int WB_SEL_WIDTH  = WB_DATA_WIDTH / 8;   // Byte lanes

  // ------------------------------------------------------------------
  // Register map of the adder slave
  // ------------------------------------------------------------------

  localparam logic [WB_ADDR_WIDTH-1:0] REG_A_LO   = WB_ADDR_WIDTH'(0);
  localparam logic [WB_ADDR_WIDTH-1:0] REG_A_HI   = WB_ADDR_WIDTH'(1);
  localparam logic [WB_ADDR_WIDTH-1:0] REG_B_LO   = WB_ADDR_WIDTH'(2);
  localparam logic [WB_ADDR_WIDTH-1:0] REG_B_HI   = WB_ADDR_WIDTH'(3);
  localparam logic [WB_ADDR_WIDTH-1:0] REG_CTRL   = WB_ADDR_WIDTH'(4);
  localparam logic [WB_ADDR_WIDTH-1:0] REG_SUM_LO = WB_ADDR_WIDTH'(5);  // Read only
  localparam logic [WB_ADDR_WIDTH-1:0] REG_SUM_HI = WB_ADDR_WIDTH'(6);  // Read only
  localparam logic [WB_ADDR_WIDTH-1:0] REG_STATUS = WB_ADDR_WIDTH'(7);  // Read only

  localparam int CTRL_CIN_BIT    = 0;   // Carry in inside REG_CTRL
  localparam int STATUS_COUT_BIT = 0;   // Carry out inside REG_STATUS

endpackage

/* test/adder_golden.mem */
// Columns: operand A, operand B, carry in, expected sum, expected carry out
// One vector per line, all values in hex
0000000000000000 0000000000000000 0 0000000000000000 0
0000000000000000 0000000000000000 1 0000000000000001 0
FFFFFFFFFFFFFFFF 0000000000000001 0 0000000000000000 1
FFFFFFFFFFFFFFFF 0000000000000000 1 0000000000000000 1
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0 FFFFFFFFFFFFFFFE 1
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 1 FFFFFFFFFFFFFFFF 1
8000000000000000 8000000000000000 0 0000000000000000 1
5555555555555555 AAAAAAAAAAAAAAAA 0 FFFFFFFFFFFFFFFF 0
5555555555555555 AAAAAAAAAAAAAAAA 1 0000000000000000 1
0123456789ABCDEF 1111111111111111 0 123456789ABCDF00 0
000000000000000F 0000000000000001 0 0000000000000010 0
00000000000000FF 0000000000000001 0 0000000000000100 0
0000000000000FFF 0000000000000001 0 0000000000001000 0
000000000000FFFF 0000000000000001 0 0000000000010000 0
00000000000FFFFF 0000000000000001 0 0000000000100000 0
0000000000FFFFFF 0000000000000001 0 0000000001000000 0
000000000FFFFFFF 0000000000000001 0 0000000010000000 0
00000000FFFFFFFF 0000000000000001 0 0000000100000000 0
0000000FFFFFFFFF 0000000000000001 0 0000001000000000 0
000000FFFFFFFFFF 0000000000000001 0 0000010000000000 0
00000FFFFFFFFFFF 0000000000000001 0 0000100000000000 0
0000FFFFFFFFFFFF 0000000000000001 0 0001000000000000 0
000FFFFFFFFFFFFF 0000000000000001 0 0010000000000000 0
00FFFFFFFFFFFFFF 0000000000000001 0 0100000000000000 0
0FFFFFFFFFFFFFFF 0000000000000001 0 1000000000000000 0
00000000FFFFFFFF 0000000000000000 1 0000000100000000 0
7FFFFFFFFFFFFFFF 0000000000000001 0 8000000000000000 0
F0F0F0F0F0F0F0F0 0F0F0F0F0F0F0F0F 1 0000000000000000 1
0000000100000000 00000000FFFFFFFF 0 00000001FFFFFFFF 0
FFFFFFFF00000000 0000000100000000 0 0000000000000000 1
0123456789ABCDEF FEDCBA9876543210 0 FFFFFFFFFFFFFFFF 0
0123456789ABCDEF FEDCBA9876543210 1 0000000000000000 1
FFFFFFFFFFFFFFF0 0000000000000010 0 0000000000000000 1
00000000000000FF 0000000000000000 1 0000000000000100 0
1000000000000000 F000000000000000 0 0000000000000000 1
0000000000000001 FFFFFFFFFFFFFFFF 1 0000000000000001 1

/* test/tb_adder.sv */
`timescale 1ns/1ps

module tb_adder
  import adder_pkg::*;
  import wb_pkg::*;
();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 4;
  localparam int GOLDEN_COUNT = 36;
  localparam int RANDOM_COUNT = 200;
  localparam int ACK_LIMIT    = 16;   // Cycles to wait for one ack
  // Five writes and three reads per vector, two cycles each, margin of two
  localparam int WATCHDOG_NS  = (GOLDEN_COUNT + RANDOM_COUNT) * 8 * 2 * CLK_PERIOD * 2
                                + (RESET_CYCLES + 200) * CLK_PERIOD;

  logic                     clk;
  logic                     rst_n;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [WB_ADDR_WIDTH-1:0] wb_adr;
  logic [WB_DATA_WIDTH-1:0] wb_wdata;
  logic [WB_SEL_WIDTH-1:0]  wb_sel;
  logic [WB_DATA_WIDTH-1:0] wb_rdata;
  logic                     wb_ack;

  operand_t    golden_mem [0:GOLDEN_COUNT*5-1];   // A, B, cin, sum, cout per vector
  int          errors;
  int          checks;
  logic [31:0] rand_state;

  adder_wb_top uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_sel   (wb_sel),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // ------------------------------------------------------------------
  // Reference model and helpers
  // ------------------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Carry out lands in the extra top bit
  function automatic logic [DATA_WIDTH:0] expected_add(input operand_t a, b, input logic cin);
    return {1'b0, a} + {1'b0, b} + {{DATA_WIDTH{1'b0}}, cin};
  endfunction

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at time %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // Called at a falling edge, returns at the falling edge that shows the ack
  task automatic wait_ack(input logic [WB_ADDR_WIDTH-1:0] addr);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!wb_ack && cycles < ACK_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!wb_ack)
    begin
      errors++;
      $display("Bus transfer to address %0d was never acknowledged", addr);
    end
  endtask

  task automatic bus_write(input logic [WB_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                           input logic [WB_SEL_WIDTH-1:0] sel);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = addr;
    wb_wdata = data;
    wb_sel   = sel;
    wait_ack(addr);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_read(input logic [WB_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = addr;
    wb_sel = 4'hF;
    wait_ack(addr);
    data   = wb_rdata;   // Valid while ack is high
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic load_operands(input operand_t a, b, input logic cin);
    bus_write(REG_A_LO, a[31:0], 4'hF);
    bus_write(REG_A_HI, a[63:32], 4'hF);
    bus_write(REG_B_LO, b[31:0], 4'hF);
    bus_write(REG_B_HI, b[63:32], 4'hF);
    bus_write(REG_CTRL, {31'b0, cin}, 4'hF);
  endtask

  task automatic check_sum(input operand_t exp_sum, input logic exp_cout, input string label);
    logic [31:0] rd;
    bus_read(REG_SUM_LO, rd);
    check_word({label, " sum low"}, rd, exp_sum[31:0]);
    bus_read(REG_SUM_HI, rd);
    check_word({label, " sum high"}, rd, exp_sum[63:32]);
    bus_read(REG_STATUS, rd);
    check_word({label, " carry out"}, rd, {31'b0, exp_cout});
  endtask

  // ------------------------------------------------------------------
  // Watchdog
  // ------------------------------------------------------------------

  initial
  begin
    #(WATCHDOG_NS);
    $display("Simulation timed out after %0d ns", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------

  initial
  begin
    operand_t            a;
    operand_t            b;
    logic                cin;
    logic [DATA_WIDTH:0] full;
    logic [31:0]         rd;
    $timeformat(-9, 0, " ns", 0);
    clk        = 1'b0;
    rst_n      = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_wdata   = '0;
    wb_sel     = '0;
    errors     = 0;
    checks     = 0;
    rand_state = 32'd55;

    // Address dependent fill shows up as a bad carry field if the file is short
    for (int i = 0; i < GOLDEN_COUNT * 5; i++)
      golden_mem[i] = {32'hBAD05EED, 32'(i)};
    $readmemh("test/adder_golden.mem", golden_mem);
    for (int i = 0; i < GOLDEN_COUNT; i++)
      if (golden_mem[i*5+2] > 64'd1 || golden_mem[i*5+4] > 64'd1)
      begin
        errors++;
        $display("Golden file entry %0d is missing or malformed", i);
      end

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Reset state
    check_sum('0, 1'b0, "after reset");
    bus_read(REG_CTRL, rd);
    check_word("control after reset", rd, 32'h0);

    for (int i = 0; i < GOLDEN_COUNT; i++)
    begin
      load_operands(golden_mem[i*5], golden_mem[i*5+1], golden_mem[i*5+2][0]);
      check_sum(golden_mem[i*5+3], golden_mem[i*5+4][0], $sformatf("golden vector %0d", i));
    end

    for (int i = 0; i < RANDOM_COUNT; i++)
    begin
      rand_state = lcg_next(rand_state);
      a[63:32]   = rand_state;
      rand_state = lcg_next(rand_state);
      a[31:0]    = rand_state;
      rand_state = lcg_next(rand_state);
      b[63:32]   = rand_state;
      rand_state = lcg_next(rand_state);
      b[31:0]    = rand_state;
      if (i % 8 == 7)
        b = ~a;   // Full length propagate chain
      rand_state = lcg_next(rand_state);
      cin        = rand_state[31];
      full       = expected_add(a, b, cin);
      load_operands(a, b, cin);
      check_sum(full[DATA_WIDTH-1:0], full[DATA_WIDTH], $sformatf("random vector %0d", i));
    end

    // Operand readback, then partial writes by byte lane
    a = 64'h0123456789ABCDEF;
    b = 64'hFEDCBA9876543210;
    load_operands(a, b, 1'b1);
    bus_read(REG_A_LO, rd);
    check_word("A low readback", rd, 32'h89ABCDEF);
    bus_read(REG_A_HI, rd);
    check_word("A high readback", rd, 32'h01234567);
    bus_read(REG_B_LO, rd);
    check_word("B low readback", rd, 32'h76543210);
    bus_read(REG_B_HI, rd);
    check_word("B high readback", rd, 32'hFEDCBA98);
    bus_read(REG_CTRL, rd);
    check_word("control readback", rd, 32'h1);

    bus_write(REG_A_LO, 32'hAABBCCDD, 4'b0101);   // Lanes 0 and 2 only
    bus_write(REG_B_HI, 32'h11223344, 4'b1000);   // Lane 3 only
    bus_write(REG_CTRL, 32'h0, 4'b1110);          // Carry in lives in lane 0
    bus_read(REG_A_LO, rd);
    check_word("A low partial write", rd, 32'h89BBCDDD);
    bus_read(REG_B_HI, rd);
    check_word("B high partial write", rd, 32'h11DCBA98);
    bus_read(REG_CTRL, rd);
    check_word("control partial write", rd, 32'h1);
    a    = 64'h0123456789BBCDDD;
    b    = 64'h11DCBA9876543210;
    full = expected_add(a, b, 1'b1);
    check_sum(full[DATA_WIDTH-1:0], full[DATA_WIDTH], "after partial writes");

    // Result registers ignore writes
    bus_write(REG_SUM_LO, 32'hDEADBEEF, 4'hF);
    bus_write(REG_SUM_HI, 32'hCAFEF00D, 4'hF);
    bus_write(REG_STATUS, 32'hFFFFFFFF, 4'hF);
    check_sum(full[DATA_WIDTH-1:0], full[DATA_WIDTH], "after read-only writes");
    bus_read(REG_A_LO, rd);
    check_word("A low after read-only writes", rd, 32'h89BBCDDD);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
